/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // funct3 encodings
    localparam funct3_t FUNCT3_LB   = 3'b000;
    localparam funct3_t FUNCT3_LH   = 3'b001;
    localparam funct3_t FUNCT3_LW   = 3'b010;
    localparam funct3_t FUNCT3_LBU  = 3'b100;
    localparam funct3_t FUNCT3_LHU  = 3'b101;

    localparam funct3_t FUNCT3_SB   = 3'b000;
    localparam funct3_t FUNCT3_SH   = 3'b001;
    localparam funct3_t FUNCT3_SW   = 3'b010;

    localparam funct3_t FUNCT3_BEQ  = 3'b000;
    localparam funct3_t FUNCT3_BNE  = 3'b001;
    localparam funct3_t FUNCT3_BLT  = 3'b100;
    localparam funct3_t FUNCT3_BGE  = 3'b101;
    localparam funct3_t FUNCT3_BLTU = 3'b110;
    localparam funct3_t FUNCT3_BGEU = 3'b111;

    localparam funct3_t FUNCT3_ADD  = 3'b000;  // Also SUB on OP
    localparam funct3_t FUNCT3_SLL  = 3'b001;
    localparam funct3_t FUNCT3_SLT  = 3'b010;
    localparam funct3_t FUNCT3_SLTU = 3'b011;
    localparam funct3_t FUNCT3_XOR  = 3'b100;
    localparam funct3_t FUNCT3_SR   = 3'b101;  // SRL or SRA
    localparam funct3_t FUNCT3_OR   = 3'b110;
    localparam funct3_t FUNCT3_AND  = 3'b111;

endpackage

/* common/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction sequencing states
    typedef enum logic [2:0] {
        ST_RESET     = 3'd0,
        ST_FETCH     = 3'd1,
        ST_REG_READ  = 3'd2,
        ST_EXECUTE   = 3'd3,
        ST_MEMORY    = 3'd4,
        ST_REG_WRITE = 3'd5
    } cpu_state_e;

    // Outgoing Wishbone request, held until ack
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [3:0]          sel;
        rv_isa_pkg::word_t   adr;
        rv_isa_pkg::word_t   dat;
    } bus_req_t;

    // Fields pulled out of the instruction register
    typedef struct packed {
        rv_isa_pkg::opcode_t  opcode;
        rv_isa_pkg::funct3_t  funct3;
        logic                 funct7_5;  // SUB / SRA select
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
    } decoded_t;

endpackage

/* core/cpu_ctrl.sv */
`timescale 1ns/10ps

module cpu_ctrl #(
    parameter rv_isa_pkg::word_t INITIAL_PC = '0
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  rv_isa_pkg::word_t       dat_i,
    input  logic                    ack_i,
    output cpu_ctrl_pkg::bus_req_t  bus_o,
    output cpu_ctrl_pkg::decoded_t  dec_o,
    output rv_isa_pkg::word_t       instr_o,
    output rv_isa_pkg::word_t       pc_o,
    output logic                    rd_we_o,
    output rv_isa_pkg::word_t       rd_data_o,
    input  rv_isa_pkg::word_t       rs1_val_i,
    input  rv_isa_pkg::word_t       rs2_val_i,
    input  rv_isa_pkg::word_t       alu_res_i,
    input  rv_isa_pkg::word_t       alu_target_i,
    input  logic                    branch_taken_i,
    input  logic [3:0]              lsu_sel_i,
    input  rv_isa_pkg::word_t       lsu_wdata_i,
    input  rv_isa_pkg::word_t       lsu_rdata_i,
    output rv_isa_pkg::word_t       mem_rdata_o,
    output rv_isa_pkg::word_t       mem_addr_o
);

    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    cpu_state_e state_q;
    word_t      pc_q;
    word_t      instr_q;
    word_t      res_q;      // ALU result registered at end of execute
    word_t      target_q;   // Next pc on redirect
    logic       redirect_q;
    word_t      rdata_q;

    logic  is_load;
    logic  is_store;
    logic  is_jalr;
    logic  mem_access;
    logic  writes_rd;
    word_t jalr_sum;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    assign dec_o.opcode   = instr_q[6:0];
    assign dec_o.funct3   = instr_q[14:12];
    assign dec_o.funct7_5 = instr_q[30];
    assign dec_o.rd       = instr_q[11:7];
    assign dec_o.rs1      = instr_q[19:15];
    assign dec_o.rs2      = instr_q[24:20];

    assign is_load    = (dec_o.opcode == OPCODE_LOAD);
    assign is_store   = (dec_o.opcode == OPCODE_STORE);
    assign is_jalr    = (dec_o.opcode == OPCODE_JALR);
    assign mem_access = is_load | is_store;

    always_comb begin
        case (dec_o.opcode)
            OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC,
            OPCODE_JAL, OPCODE_JALR, OPCODE_LOAD: writes_rd = 1'b1;
            default:                              writes_rd = 1'b0;
        endcase
    end

    // JALR goes to rs1 + I-immediate
    assign jalr_sum = rs1_val_i + {{20{instr_q[31]}}, instr_q[31:20]};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine and program counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_RESET;
            pc_q    <= INITIAL_PC;
        end else begin
            case (state_q)
                ST_RESET:    state_q <= ST_FETCH;
                ST_FETCH:    if (ack_i) state_q <= ST_REG_READ;
                ST_REG_READ: state_q <= ST_EXECUTE;
                ST_EXECUTE:  state_q <= ST_MEMORY;
                ST_MEMORY:   if (!mem_access || ack_i) state_q <= ST_REG_WRITE;
                ST_REG_WRITE: begin
                    state_q <= ST_FETCH;
                    pc_q    <= redirect_q ? target_q : pc_q + 32'd4;
                end
                default:     state_q <= ST_RESET;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_FETCH && ack_i)
            instr_q <= dat_i;
        if (state_q == ST_EXECUTE) begin
            res_q      <= alu_res_i;
            target_q   <= is_jalr ? {jalr_sum[31:1], 1'b0} : alu_target_i;
            redirect_q <= is_jalr || (dec_o.opcode == OPCODE_JAL) || branch_taken_i;
        end
        if (state_q == ST_MEMORY && ack_i)
            rdata_q <= dat_i;  // Load word
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus request
    always_comb begin
        bus_o = '0;
        if (state_q == ST_FETCH) begin
            bus_o.cyc = 1'b1;
            bus_o.stb = 1'b1;
            bus_o.sel = 4'b1111;
            bus_o.adr = pc_q;
        end else if (state_q == ST_MEMORY && mem_access) begin
            bus_o.cyc = 1'b1;
            bus_o.stb = 1'b1;
            bus_o.we  = is_store;
            bus_o.sel = is_store ? lsu_sel_i : 4'b1111;
            bus_o.adr = {res_q[31:2], 2'b00};
            if (is_store)
                bus_o.dat = lsu_wdata_i;
        end
    end

    assign rd_we_o   = (state_q == ST_REG_WRITE) && writes_rd && (dec_o.rd != '0);
    assign rd_data_o = is_load ? lsu_rdata_i : res_q;

    assign instr_o     = instr_q;
    assign pc_o        = pc_q;
    assign mem_rdata_o = rdata_q;
    assign mem_addr_o  = res_q;

endmodule

/* core/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                 clk_i,
    input  rv_isa_pkg::reg_idx_t rs1_i,
    input  rv_isa_pkg::reg_idx_t rs2_i,
    input  rv_isa_pkg::reg_idx_t rd_i,
    input  logic                 we_i,
    input  rv_isa_pkg::word_t    wdata_i,
    output rv_isa_pkg::word_t    rs1_val_o,
    output rv_isa_pkg::word_t    rs2_val_o
);

    import rv_isa_pkg::*;

    word_t regs [32];

    // Single write port
    always_ff @(posedge clk_i) begin
        if (we_i && rd_i != '0)
            regs[rd_i] <= wdata_i;
    end

    // Asynchronous reads, x0 hardwired
    assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* core/imm_decode.sv */
`timescale 1ns/10ps

module imm_decode (
    input  rv_isa_pkg::word_t      instr_i,
    input  cpu_ctrl_pkg::decoded_t dec_i,
    output rv_isa_pkg::word_t      imm_o
);

    import rv_isa_pkg::*;

    word_t imm_i_fmt;
    word_t imm_s_fmt;
    word_t imm_b_fmt;
    word_t imm_u_fmt;
    word_t imm_j_fmt;

    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_fmt = {instr_i[31:12], 12'b0};
    assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};

    // Format follows the opcode
    always_comb begin
        case (dec_i.opcode)
            OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR: imm_o = imm_i_fmt;
            OPCODE_STORE:                            imm_o = imm_s_fmt;
            OPCODE_BRANCH:                           imm_o = imm_b_fmt;
            OPCODE_LUI, OPCODE_AUIPC:                imm_o = imm_u_fmt;
            OPCODE_JAL:                              imm_o = imm_j_fmt;
            default:                                 imm_o = '0;  // OP has none
        endcase
    end

endmodule

/* core/alu.sv */
`timescale 1ns/10ps

module alu (
    input  cpu_ctrl_pkg::decoded_t dec_i,
    input  rv_isa_pkg::word_t      rs1_val_i,
    input  rv_isa_pkg::word_t      rs2_val_i,
    input  rv_isa_pkg::word_t      imm_i,
    input  rv_isa_pkg::word_t      pc_i,
    output rv_isa_pkg::word_t      res_o,
    output rv_isa_pkg::word_t      target_o,
    output logic                   taken_o
);

    import rv_isa_pkg::*;

    word_t      op_b;
    word_t      arith;
    logic [4:0] shamt;
    logic       is_sub;
    logic       eq;
    logic       lt;
    logic       ltu;
    logic       cond;

    assign op_b   = (dec_i.opcode == OPCODE_OP) ? rs2_val_i : imm_i;
    assign shamt  = op_b[4:0];
    assign is_sub = (dec_i.opcode == OPCODE_OP) && dec_i.funct7_5;  // ADDI has no SUB

    always_comb begin
        case (dec_i.funct3)
            FUNCT3_ADD:  arith = is_sub ? rs1_val_i - op_b : rs1_val_i + op_b;
            FUNCT3_SLL:  arith = rs1_val_i << shamt;
            FUNCT3_SLT:  arith = {31'b0, $signed(rs1_val_i) < $signed(op_b)};
            FUNCT3_SLTU: arith = {31'b0, rs1_val_i < op_b};
            FUNCT3_XOR:  arith = rs1_val_i ^ op_b;
            FUNCT3_SR:   arith = dec_i.funct7_5 ? word_t'($signed(rs1_val_i) >>> shamt)
                                                : rs1_val_i >> shamt;
            FUNCT3_OR:   arith = rs1_val_i | op_b;
            default:     arith = rs1_val_i & op_b;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result per instruction class
    always_comb begin
        case (dec_i.opcode)
            OPCODE_OP, OPCODE_OP_IMM:    res_o = arith;
            OPCODE_LUI:                  res_o = imm_i;
            OPCODE_AUIPC:                res_o = pc_i + imm_i;
            OPCODE_JAL, OPCODE_JALR:     res_o = pc_i + 32'd4;  // Link value
            OPCODE_LOAD, OPCODE_STORE:   res_o = rs1_val_i + imm_i;
            default:                     res_o = '0;
        endcase
    end

    // Branch compare always on rs1 vs rs2
    assign eq  = (rs1_val_i == rs2_val_i);
    assign lt  = ($signed(rs1_val_i) < $signed(rs2_val_i));
    assign ltu = (rs1_val_i < rs2_val_i);

    always_comb begin
        case (dec_i.funct3)
            FUNCT3_BEQ:  cond = eq;
            FUNCT3_BNE:  cond = !eq;
            FUNCT3_BLT:  cond = lt;
            FUNCT3_BGE:  cond = !lt;
            FUNCT3_BLTU: cond = ltu;
            FUNCT3_BGEU: cond = !ltu;
            default:     cond = 1'b0;
        endcase
    end

    assign taken_o  = (dec_i.opcode == OPCODE_BRANCH) && cond;
    assign target_o = pc_i + imm_i;  // Branch and JAL

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/10ps

module load_store_unit (
    input  rv_isa_pkg::funct3_t funct3_i,
    input  logic [1:0]          addr_lo_i,
    input  rv_isa_pkg::word_t   wdata_i,
    input  rv_isa_pkg::word_t   rdata_i,
    output logic [3:0]          sel_o,
    output rv_isa_pkg::word_t   wdata_o,
    output rv_isa_pkg::word_t   load_o
);

    import rv_isa_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Store side
    always_comb begin
        case (funct3_i)
            FUNCT3_SB: begin
                sel_o   = 4'b0001 << addr_lo_i;
                wdata_o = {4{wdata_i[7:0]}};
            end
            FUNCT3_SH: begin
                sel_o   = addr_lo_i[1] ? 4'b1100 : 4'b0011;
                wdata_o = {2{wdata_i[15:0]}};
            end
            FUNCT3_SW: begin
                sel_o   = 4'b1111;
                wdata_o = wdata_i;
            end
            default: begin
                sel_o   = 4'b0000;
                wdata_o = '0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load side
    assign ld_byte = rdata_i[{addr_lo_i, 3'b000} +: 8];
    assign ld_half = rdata_i[{addr_lo_i[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3_i)
            FUNCT3_LB:  load_o = {{24{ld_byte[7]}}, ld_byte};
            FUNCT3_LBU: load_o = {24'b0, ld_byte};
            FUNCT3_LH:  load_o = {{16{ld_half[15]}}, ld_half};
            FUNCT3_LHU: load_o = {16'b0, ld_half};
            default:    load_o = rdata_i;  // LW
        endcase
    end

endmodule

/* hdl/rv_cpu_top.sv */
`timescale 1ns/10ps

module rv_cpu_top #(
    parameter rv_isa_pkg::word_t INITIAL_PC = '0
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  rv_isa_pkg::word_t      dat_i,
    input  logic                   ack_i,
    output cpu_ctrl_pkg::bus_req_t bus_o
);

    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    decoded_t   dec;
    word_t      instr;
    word_t      pc;
    logic       rd_we;
    word_t      rd_data;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    word_t      alu_res;
    word_t      alu_target;
    logic       branch_taken;
    logic [3:0] lsu_sel;
    word_t      lsu_wdata;
    word_t      lsu_rdata;
    word_t      mem_rdata;
    word_t      mem_addr;

    cpu_ctrl #(.INITIAL_PC(INITIAL_PC)) u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i), .dat_i(dat_i), .ack_i(ack_i), .bus_o(bus_o),
        .dec_o(dec), .instr_o(instr), .pc_o(pc),
        .rd_we_o(rd_we), .rd_data_o(rd_data),
        .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
        .alu_res_i(alu_res), .alu_target_i(alu_target), .branch_taken_i(branch_taken),
        .lsu_sel_i(lsu_sel), .lsu_wdata_i(lsu_wdata), .lsu_rdata_i(lsu_rdata),
        .mem_rdata_o(mem_rdata), .mem_addr_o(mem_addr)
    );

    register_file u_regs (
        .clk_i(clk_i), .rs1_i(dec.rs1), .rs2_i(dec.rs2), .rd_i(dec.rd),
        .we_i(rd_we), .wdata_i(rd_data), .rs1_val_o(rs1_val), .rs2_val_o(rs2_val)
    );

    imm_decode u_imm (.instr_i(instr), .dec_i(dec), .imm_o(imm));

    alu u_alu (
        .dec_i(dec), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val), .imm_i(imm), .pc_i(pc),
        .res_o(alu_res), .target_o(alu_target), .taken_o(branch_taken)
    );

    // Lane logic sees the registered effective address
    load_store_unit u_lsu (
        .funct3_i(dec.funct3), .addr_lo_i(mem_addr[1:0]), .wdata_i(rs2_val),
        .rdata_i(mem_rdata), .sel_o(lsu_sel), .wdata_o(lsu_wdata), .load_o(lsu_rdata)
    );

endmodule

/* tb/rv_cpu_properties.sv */
`timescale 1ns/10ps

module rv_cpu_properties (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     ack_i,
    input  cpu_ctrl_pkg::bus_req_t   bus_o,
    input  cpu_ctrl_pkg::cpu_state_e state_i
);

    import cpu_ctrl_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus protocol
    req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (bus_o.cyc && bus_o.stb && !ack_i) |=> $stable(bus_o))
        else $error("bus request changed before ack");

    cyc_stb_equal: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_o.cyc == bus_o.stb)
        else $error("cyc and stb differ");

    idle_in_reset: assert property (@(posedge clk_i) rst_i |=> !bus_o.cyc)
        else $error("cyc high during reset");

    // State encoding stays inside the enum
    state_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        state_i inside {ST_RESET, ST_FETCH, ST_REG_READ, ST_EXECUTE, ST_MEMORY, ST_REG_WRITE})
        else $error("illegal control state");

endmodule

bind rv_cpu_top rv_cpu_properties u_props (
    .clk_i(clk_i), .rst_i(rst_i), .ack_i(ack_i), .bus_o(bus_o), .state_i(u_ctrl.state_q)
);

/* tb/tb_rv_cpu.sv */
`timescale 1ns/10ps

module tb_rv_cpu;

    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam word_t INITIAL_PC = 32'h0000_0000;

    logic     clk_i;
    logic     rst_i;
    word_t    dat_i;
    logic     ack_i;
    bus_req_t bus_o;

    word_t      mem [256];
    int         n_instr;
    string      exp_name [$];
    word_t      exp_adr [$];
    logic [3:0] exp_sel [$];
    word_t      exp_dat [$];
    int         store_idx;
    int         pass_cnt;
    int         fail_cnt;
    int         cycle_cnt;
    int         waits;
    logic       busy;
    logic       first_seen;
    logic       reset_cyc_seen;

    rv_cpu_top #(.INITIAL_PC(INITIAL_PC)) UUT (
        .clk_i(clk_i), .rst_i(rst_i), .dat_i(dat_i), .ack_i(ack_i), .bus_o(bus_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoders
    function automatic word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(int op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t s_type(int f3, int rs1, int rs2, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic word_t u_type(int op, int rd, int imm20);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input word_t w);
        mem[n_instr] = w;
        n_instr++;
    endtask

    task automatic expect_store(input string name, input word_t adr, input logic [3:0] sel,
                                input word_t dat);
        exp_name.push_back(name);
        exp_adr.push_back(adr);
        exp_sel.push_back(sel);
        exp_dat.push_back(dat);
    endtask

    function automatic word_t lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    task automatic load_program();
        emit(i_type(7'h13, 0, 2, 0, 100));            // x2 = 100
        emit(i_type(7'h13, 0, 3, 0, -7));             // x3 = -7
        emit(i_type(7'h13, 0, 1, 0, 32'h200));        // x1 = store base
        emit(r_type(0, 0, 4, 2, 3));
        emit(s_type(2, 1, 4, 0));
        emit(r_type(7'h20, 0, 4, 2, 3));
        emit(s_type(2, 1, 4, 4));
        emit(r_type(0, 4, 4, 2, 3));
        emit(s_type(2, 1, 4, 8));
        emit(r_type(0, 6, 4, 2, 3));
        emit(s_type(2, 1, 4, 12));
        emit(i_type(7'h13, 7, 4, 3, 32'hF0));
        emit(s_type(2, 1, 4, 16));
        emit(i_type(7'h13, 1, 4, 2, 4));
        emit(s_type(2, 1, 4, 20));
        emit(i_type(7'h13, 5, 4, 3, 32'h401));        // SRAI 1
        emit(s_type(2, 1, 4, 24));
        emit(i_type(7'h13, 5, 4, 3, 28));
        emit(s_type(2, 1, 4, 28));
        emit(r_type(0, 2, 4, 3, 2));
        emit(s_type(2, 1, 4, 32));
        emit(r_type(0, 3, 4, 3, 2));
        emit(s_type(2, 1, 4, 36));
        emit(u_type(7'h37, 4, 32'h12345));
        emit(s_type(2, 1, 4, 40));
        emit(u_type(7'h17, 4, 1));                    // at pc 0x64
        emit(s_type(2, 1, 4, 44));
        emit(u_type(7'h37, 5, 32'hCAFEC));
        emit(i_type(7'h13, 0, 5, 5, -1346));          // x5 = 0xCAFEBABE
        emit(s_type(0, 1, 5, 48));
        emit(s_type(0, 1, 5, 49));
        emit(s_type(0, 1, 5, 50));
        emit(s_type(0, 1, 5, 51));
        emit(s_type(1, 1, 5, 52));
        emit(s_type(1, 1, 5, 54));
        emit(i_type(7'h13, 0, 6, 0, 32'h300));        // x6 = load base
        emit(i_type(7'h03, 0, 7, 6, 0));
        emit(s_type(2, 1, 7, 56));
        emit(i_type(7'h03, 4, 7, 6, 0));
        emit(s_type(2, 1, 7, 60));
        emit(i_type(7'h03, 1, 7, 6, 2));
        emit(s_type(2, 1, 7, 64));
        emit(i_type(7'h03, 5, 7, 6, 0));
        emit(s_type(2, 1, 7, 68));
        emit(i_type(7'h03, 0, 7, 6, 3));
        emit(s_type(2, 1, 7, 72));
        // Wrong branch paths store x3
        emit(i_type(7'h13, 0, 8, 0, 32'h55));
        emit(b_type(0, 2, 3, 8));
        emit(s_type(2, 1, 8, 76));
        emit(b_type(1, 2, 3, 8));
        emit(s_type(2, 1, 3, 80));
        emit(b_type(4, 3, 2, 8));
        emit(s_type(2, 1, 3, 80));
        emit(b_type(6, 3, 2, 8));
        emit(s_type(2, 1, 8, 80));
        emit(b_type(5, 2, 3, 8));
        emit(s_type(2, 1, 3, 84));
        emit(b_type(7, 3, 2, 8));
        emit(s_type(2, 1, 3, 84));
        emit(j_type(9, 8));                           // jal at 0xEC
        emit(s_type(2, 1, 3, 84));
        emit(s_type(2, 1, 9, 84));
        emit(i_type(7'h13, 0, 10, 0, 257));
        emit(i_type(7'h67, 0, 11, 10, 4));            // jalr to 261 & ~1 at 0xFC
        emit(s_type(2, 1, 3, 88));
        emit(s_type(2, 1, 11, 88));
        emit(j_type(0, 0));                           // Park
        mem[192] = 32'hC3A5_8F81;
    endtask

    task automatic load_expected();
        expect_store("add",       32'h200, 4'hF, 32'h0000_005D);
        expect_store("sub",       32'h204, 4'hF, 32'h0000_006B);
        expect_store("xor",       32'h208, 4'hF, 32'hFFFF_FF9D);
        expect_store("or",        32'h20C, 4'hF, 32'hFFFF_FFFD);
        expect_store("andi",      32'h210, 4'hF, 32'h0000_00F0);
        expect_store("slli",      32'h214, 4'hF, 32'h0000_0640);
        expect_store("srai",      32'h218, 4'hF, 32'hFFFF_FFFC);
        expect_store("srli",      32'h21C, 4'hF, 32'h0000_000F);
        expect_store("slt",       32'h220, 4'hF, 32'h0000_0001);
        expect_store("sltu",      32'h224, 4'hF, 32'h0000_0000);
        expect_store("lui",       32'h228, 4'hF, 32'h1234_5000);
        expect_store("auipc",     32'h22C, 4'hF, 32'h0000_1064);
        expect_store("sb_0",      32'h230, 4'b0001, 32'h0000_00BE);
        expect_store("sb_1",      32'h230, 4'b0010, 32'h0000_BE00);
        expect_store("sb_2",      32'h230, 4'b0100, 32'h00BE_0000);
        expect_store("sb_3",      32'h230, 4'b1000, 32'hBE00_0000);
        expect_store("sh_0",      32'h234, 4'b0011, 32'h0000_BABE);
        expect_store("sh_2",      32'h234, 4'b1100, 32'hBABE_0000);
        expect_store("lb",        32'h238, 4'hF, 32'hFFFF_FF81);
        expect_store("lbu",       32'h23C, 4'hF, 32'h0000_0081);
        expect_store("lh",        32'h240, 4'hF, 32'hFFFF_C3A5);
        expect_store("lhu",       32'h244, 4'hF, 32'h0000_8F81);
        expect_store("lb_3",      32'h248, 4'hF, 32'hFFFF_FFC3);
        expect_store("beq_nt",    32'h24C, 4'hF, 32'h0000_0055);
        expect_store("bltu_nt",   32'h250, 4'hF, 32'h0000_0055);
        expect_store("jal_link",  32'h254, 4'hF, 32'h0000_00F0);
        expect_store("jalr_link", 32'h258, 4'hF, 32'h0000_0100);
    endtask

    task automatic check_store();
        word_t mask;
        word_t got;
        if (store_idx >= exp_name.size()) begin
            $display("Store to %h beyond the end of the expected list", bus_o.adr);
            fail_cnt++;
        end else begin
            mask = lane_mask(bus_o.sel);
            got  = bus_o.dat & mask;
            if (bus_o.adr != exp_adr[store_idx] || bus_o.sel != exp_sel[store_idx] ||
                got != exp_dat[store_idx]) begin
                $display("[FAIL] %s expected adr=%h sel=%b dat=%h actual adr=%h sel=%b dat=%h",
                         exp_name[store_idx], exp_adr[store_idx], exp_sel[store_idx],
                         exp_dat[store_idx], bus_o.adr, bus_o.sel, got);
                fail_cnt++;
            end else begin
                $display("[PASS] %s", exp_name[store_idx]);
                pass_cnt++;
            end
            store_idx++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory model samples 1 ns after the edge and drives at 2 ns
    always begin
        @(posedge clk_i);
        #1;
        if (rst_i && bus_o.cyc)
            reset_cyc_seen = 1'b1;
        if (!rst_i && bus_o.cyc && !first_seen) begin
            first_seen = 1'b1;
            if (bus_o.adr != INITIAL_PC || bus_o.we || !bus_o.stb) begin
                $display("[FAIL] first_fetch expected adr=%h we=0 stb=1 actual adr=%h we=%b stb=%b",
                         INITIAL_PC, bus_o.adr, bus_o.we, bus_o.stb);
                fail_cnt++;
            end else begin
                $display("[PASS] first_fetch");
                pass_cnt++;
            end
        end
        #1;
        if (ack_i) begin
            ack_i = 1'b0;  // Consumed on the last edge
            busy  = 1'b0;
        end else if (!rst_i && bus_o.cyc && bus_o.stb) begin
            if (!busy) begin
                busy  = 1'b1;
                waits = $urandom % 3;
                if (bus_o.adr[1:0] != 2'b00) begin
                    $display("Bus access to %h is not word aligned", bus_o.adr);
                    fail_cnt++;
                end
            end
            if (waits == 0) begin
                ack_i = 1'b1;
                dat_i = mem[bus_o.adr[9:2]];
                if (bus_o.we) begin
                    mem[bus_o.adr[9:2]] = (mem[bus_o.adr[9:2]] & ~lane_mask(bus_o.sel)) |
                                          (bus_o.dat & lane_mask(bus_o.sel));
                    check_store();
                end
            end else begin
                waits--;
            end
        end
    end

    initial begin
        int limit;
        void'($urandom(32'h96a9099d));
        clk_i = 1'b0;
        rst_i = 1'b1;
        dat_i = '0;
        ack_i = 1'b0;
        busy = 1'b0;
        waits = 0;
        first_seen = 1'b0;
        reset_cyc_seen = 1'b0;
        store_idx = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        cycle_cnt = 0;
        n_instr = 0;
        for (int i = 0; i < 256; i++)
            mem[i] = 32'hA5A5_0000 | i;
        load_program();
        load_expected();
        limit = n_instr * 9 * 2;

        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        if (reset_cyc_seen) begin
            $display("cyc went high while reset was asserted");
            fail_cnt++;
        end else begin
            $display("[PASS] reset_idle");
            pass_cnt++;
        end

        while (store_idx < exp_name.size() && cycle_cnt < limit)
            @(posedge clk_i);
        repeat (2) @(posedge clk_i);

        if (store_idx < exp_name.size()) begin
            $display("Run timed out after %0d cycles with %0d of %0d stores seen",
                     cycle_cnt, store_idx, exp_name.size());
            fail_cnt++;
        end
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* build.f */
common/rv_isa_pkg.sv
common/cpu_ctrl_pkg.sv
core/cpu_ctrl.sv
core/register_file.sv
core/imm_decode.sv
core/alu.sv
hdl/load_store_unit.sv
hdl/rv_cpu_top.sv
tb/rv_cpu_properties.sv
tb/tb_rv_cpu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_cpu
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
